//--- design/rv_decode_params.svh
`ifndef RV_DECODE_PARAMS_SVH
`define RV_DECODE_PARAMS_SVH

// Data path width
`define RV_XLEN 64

// Fetched instruction word width
`define RV_ILEN 32

// Register address width
`define RV_REG_W 5

// Major opcode field width
`define RV_OPCODE_W 7

`endif

//--- design/rv_decode_pkg.sv
`include "rv_decode_params.svh"

package rv_decode_pkg;

  // Major opcodes that the decoder recognises
  typedef enum logic [`RV_OPCODE_W-1:0] {
    OPCODE_LOAD      = 7'b0000011,
    OPCODE_OP_IMM    = 7'b0010011,
    OPCODE_AUIPC     = 7'b0010111,
    OPCODE_OP_IMM_32 = 7'b0011011,
    OPCODE_STORE     = 7'b0100011,
    OPCODE_OP        = 7'b0110011,
    OPCODE_LUI       = 7'b0110111,
    OPCODE_OP_32     = 7'b0111011,
    OPCODE_BRANCH    = 7'b1100011,
    OPCODE_JALR      = 7'b1100111,
    OPCODE_JAL       = 7'b1101111,
    OPCODE_SYSTEM    = 7'b1110011
  } opcode_e;

  typedef enum logic [2:0] {
    OP_ALU, OP_BRANCH, OP_JUMP, OP_MEM, OP_SYSTEM
  } op_type_e;

  typedef enum logic [2:0] {
    ALU_ADD, ALU_SUB, ALU_SCC, ALU_XOR, ALU_OR, ALU_AND, ALU_SHIFT
  } alu_op_e;

  typedef enum logic [1:0] {
    SHIFT_OP_SLL, SHIFT_OP_SRL, SHIFT_OP_SRA
  } shift_op_e;

  // Same encoding as the branch funct3
  typedef enum logic [2:0] {
    CC_EQ  = 3'b000,
    CC_NE  = 3'b001,
    CC_LT  = 3'b100,
    CC_GE  = 3'b101,
    CC_LTU = 3'b110,
    CC_GEU = 3'b111
  } cond_e;

  typedef enum logic {
    SIZE_EXT_SIGNED, SIZE_EXT_ZERO
  } size_ext_e;

  typedef enum logic {
    MEM_LOAD, MEM_STORE
  } mem_op_e;

  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_S = 2'b01,
    PRIV_LVL_M = 2'b11
  } priv_lvl_e;

  typedef enum logic [3:0] {
    EXC_CAUSE_ILLEGAL_INSN = 4'd2,
    EXC_CAUSE_BREAKPOINT   = 4'd3,
    EXC_CAUSE_ECALL_UMODE  = 4'd8,
    EXC_CAUSE_ECALL_SMODE  = 4'd9,
    EXC_CAUSE_ECALL_MMODE  = 4'd11
  } exc_cause_e;

  // Per-stage item slot
  typedef enum logic [1:0] {
    SLOT_EMPTY, SLOT_FULL_WAIT_REQ_LOW, SLOT_SENDING, SLOT_WAIT_ACK_LOW
  } slot_state_e;

  typedef struct packed {
    logic [`RV_ILEN-1:0] instr;
    logic [`RV_XLEN-1:0] pc;
    priv_lvl_e           prv;
  } fetch_item_t;

  typedef struct packed {
    fetch_item_t             fetch;
    logic [`RV_XLEN-1:0]     imm;
    logic [`RV_OPCODE_W-1:0] opcode;
    logic [2:0]              funct3;
    logic [6:0]              funct7;
    logic [`RV_REG_W-1:0]    rd;
    logic [`RV_REG_W-1:0]    rs1;
    logic [`RV_REG_W-1:0]    rs2;
  } field_item_t;

  typedef struct packed {
    logic [`RV_XLEN-1:0]  pc;
    logic [`RV_ILEN-1:0]  instr;
    priv_lvl_e            prv;
    logic [`RV_XLEN-1:0]  imm;
    op_type_e             op_type;
    alu_op_e              alu_op;
    shift_op_e            shift_op;
    cond_e                condition;
    logic [1:0]           size;
    size_ext_e            size_ext;
    mem_op_e              mem_op;
    logic [`RV_REG_W-1:0] rd;
    logic [`RV_REG_W-1:0] rs1;
    logic [`RV_REG_W-1:0] rs2;
    logic                 use_imm;
    logic                 adder_use_pc;
    logic                 adder_use_imm;
    logic                 illegal;
    logic                 ecall;
    logic                 ebreak;
    logic                 eret;
  } op_item_t;

  typedef struct packed {
    logic [`RV_XLEN-1:0]  pc;
    logic [`RV_XLEN-1:0]  imm;
    op_type_e             op_type;
    alu_op_e              alu_op;
    shift_op_e            shift_op;
    cond_e                condition;
    logic [1:0]           size;
    size_ext_e            size_ext;
    mem_op_e              mem_op;
    logic [`RV_REG_W-1:0] rd;
    logic [`RV_REG_W-1:0] rs1;
    logic [`RV_REG_W-1:0] rs2;
    logic                 use_imm;
    logic                 adder_use_pc;
    logic                 adder_use_imm;
    logic                 illegal;
    logic                 ecall;
    logic                 ebreak;
    logic                 eret;
    logic                 ex_valid;
    exc_cause_e           cause;
    logic [`RV_XLEN-1:0]  tval;
  } decoded_item_t;

endpackage

//--- design/rv_field_stage.sv
`timescale 1ns/1ns
`include "rv_decode_params.svh"

module rv_field_stage (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic                       in_req_i,
  input  rv_decode_pkg::fetch_item_t in_data_i,
  output logic                       in_ack_o,
  output logic                       out_req_o,
  output rv_decode_pkg::field_item_t out_data_o,
  input  logic                       out_ack_i
);

  rv_decode_pkg::slot_state_e state_q;
  rv_decode_pkg::fetch_item_t hold_q;
  rv_decode_pkg::field_item_t field_d;

  logic capture;
  logic launch;

  assign capture = state_q == rv_decode_pkg::SLOT_EMPTY && in_req_i && !in_ack_o;
  assign launch  = state_q == rv_decode_pkg::SLOT_FULL_WAIT_REQ_LOW;

  ////////////////////
  // Handshake slot
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q   <= rv_decode_pkg::SLOT_EMPTY;
      in_ack_o  <= 1'b0;
      out_req_o <= 1'b0;
    end else begin
      // Ack falls once the sender has let go of req
      if (in_ack_o && !in_req_i) in_ack_o <= 1'b0;
      unique case (state_q)
        rv_decode_pkg::SLOT_EMPTY: begin
          if (capture) begin
            in_ack_o <= 1'b1;
            state_q  <= rv_decode_pkg::SLOT_FULL_WAIT_REQ_LOW;
          end
        end
        rv_decode_pkg::SLOT_FULL_WAIT_REQ_LOW: begin
          out_req_o <= 1'b1;
          state_q   <= rv_decode_pkg::SLOT_SENDING;
        end
        rv_decode_pkg::SLOT_SENDING: begin
          if (out_ack_i) begin
            out_req_o <= 1'b0;
            state_q   <= rv_decode_pkg::SLOT_WAIT_ACK_LOW;
          end
        end
        default: begin
          if (!out_ack_i) state_q <= rv_decode_pkg::SLOT_EMPTY;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (capture) hold_q <= in_data_i;
    if (launch) out_data_o <= field_d;
  end

  ////////////////////
  // Field split
  ////////////////////

  logic [`RV_ILEN-1:0] instr;
  assign instr = hold_q.instr;

  always_comb begin
    field_d.fetch  = hold_q;
    field_d.opcode = instr[6:0];
    field_d.funct3 = instr[14:12];
    field_d.funct7 = instr[31:25];
    field_d.rd     = instr[11:7];
    field_d.rs1    = instr[19:15];
    field_d.rs2    = instr[24:20];

    // Immediate by format, sign extended to full width
    unique case (rv_decode_pkg::opcode_e'(instr[6:0]))
      rv_decode_pkg::OPCODE_LOAD, rv_decode_pkg::OPCODE_OP_IMM,
      rv_decode_pkg::OPCODE_OP_IMM_32, rv_decode_pkg::OPCODE_JALR:
        field_d.imm = {{(`RV_XLEN-12){instr[31]}}, instr[31:20]};
      rv_decode_pkg::OPCODE_STORE:
        field_d.imm = {{(`RV_XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
      rv_decode_pkg::OPCODE_BRANCH:
        field_d.imm = {{(`RV_XLEN-13){instr[31]}}, instr[31], instr[7], instr[30:25],
                       instr[11:8], 1'b0};
      rv_decode_pkg::OPCODE_LUI, rv_decode_pkg::OPCODE_AUIPC:
        field_d.imm = {{(`RV_XLEN-32){instr[31]}}, instr[31:12], 12'b0};
      rv_decode_pkg::OPCODE_JAL:
        field_d.imm = {{(`RV_XLEN-21){instr[31]}}, instr[31], instr[19:12], instr[20],
                       instr[30:21], 1'b0};
      default:
        field_d.imm = '0;
    endcase
  end

endmodule

//--- design/rv_op_stage.sv
`timescale 1ns/1ns

module rv_op_stage (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic                       in_req_i,
  input  rv_decode_pkg::field_item_t in_data_i,
  output logic                       in_ack_o,
  output logic                       out_req_o,
  output rv_decode_pkg::op_item_t    out_data_o,
  input  logic                       out_ack_i
);

  rv_decode_pkg::slot_state_e state_q;
  rv_decode_pkg::field_item_t hold_q;
  rv_decode_pkg::op_item_t    op_d;

  logic capture;
  logic launch;

  assign capture = state_q == rv_decode_pkg::SLOT_EMPTY && in_req_i && !in_ack_o;
  assign launch  = state_q == rv_decode_pkg::SLOT_FULL_WAIT_REQ_LOW;

  ////////////////////
  // Handshake slot
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q   <= rv_decode_pkg::SLOT_EMPTY;
      in_ack_o  <= 1'b0;
      out_req_o <= 1'b0;
    end else begin
      if (in_ack_o && !in_req_i) in_ack_o <= 1'b0;
      unique case (state_q)
        rv_decode_pkg::SLOT_EMPTY: begin
          if (capture) begin
            in_ack_o <= 1'b1;
            state_q  <= rv_decode_pkg::SLOT_FULL_WAIT_REQ_LOW;
          end
        end
        rv_decode_pkg::SLOT_FULL_WAIT_REQ_LOW: begin
          out_req_o <= 1'b1;
          state_q   <= rv_decode_pkg::SLOT_SENDING;
        end
        rv_decode_pkg::SLOT_SENDING: begin
          if (out_ack_i) begin
            out_req_o <= 1'b0;
            state_q   <= rv_decode_pkg::SLOT_WAIT_ACK_LOW;
          end
        end
        default: begin
          if (!out_ack_i) state_q <= rv_decode_pkg::SLOT_EMPTY;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (capture) hold_q <= in_data_i;
    if (launch) out_data_o <= op_d;
  end

  ////////////////////
  // Operation decode
  ////////////////////

  logic       rd_en;
  logic       rs1_en;
  logic       rs2_en;
  logic [2:0] f3;
  logic [6:0] f7;

  assign f3 = hold_q.funct3;
  assign f7 = hold_q.funct7;

  always_comb begin
    op_d = '0;
    op_d.pc       = hold_q.fetch.pc;
    op_d.instr    = hold_q.fetch.instr;
    op_d.prv      = hold_q.fetch.prv;
    op_d.imm      = hold_q.imm;
    op_d.op_type  = rv_decode_pkg::OP_ALU;
    op_d.alu_op   = rv_decode_pkg::ALU_ADD;
    op_d.shift_op = rv_decode_pkg::SHIFT_OP_SLL;
    op_d.condition = rv_decode_pkg::CC_EQ;
    op_d.size     = 2'b11;
    op_d.size_ext = rv_decode_pkg::SIZE_EXT_SIGNED;
    op_d.mem_op   = rv_decode_pkg::MEM_LOAD;
    rd_en  = 1'b0;
    rs1_en = 1'b0;
    rs2_en = 1'b0;

    unique case (rv_decode_pkg::opcode_e'(hold_q.opcode))
      rv_decode_pkg::OPCODE_JAL: begin
        op_d.op_type = rv_decode_pkg::OP_JUMP;
        op_d.adder_use_pc  = 1'b1;
        op_d.adder_use_imm = 1'b1;
        rd_en = 1'b1;
      end
      rv_decode_pkg::OPCODE_JALR: begin
        op_d.op_type = rv_decode_pkg::OP_JUMP;
        op_d.adder_use_imm = 1'b1;
        rd_en  = 1'b1;
        rs1_en = 1'b1;
        op_d.illegal = f3 != 3'b000;
      end
      rv_decode_pkg::OPCODE_BRANCH: begin
        op_d.op_type   = rv_decode_pkg::OP_BRANCH;
        op_d.condition = rv_decode_pkg::cond_e'(f3);
        op_d.adder_use_pc  = 1'b1;
        op_d.adder_use_imm = 1'b1;
        rs1_en = 1'b1;
        rs2_en = 1'b1;
        // 010 and 011 have no branch condition
        op_d.illegal = f3[2:1] == 2'b01;
      end
      rv_decode_pkg::OPCODE_LOAD: begin
        op_d.op_type  = rv_decode_pkg::OP_MEM;
        op_d.size     = f3[1:0];
        op_d.size_ext = f3[2] ? rv_decode_pkg::SIZE_EXT_ZERO : rv_decode_pkg::SIZE_EXT_SIGNED;
        op_d.adder_use_imm = 1'b1;
        rd_en  = 1'b1;
        rs1_en = 1'b1;
        op_d.illegal = f3 == 3'b111;
      end
      rv_decode_pkg::OPCODE_STORE: begin
        op_d.op_type = rv_decode_pkg::OP_MEM;
        op_d.size    = f3[1:0];
        op_d.mem_op  = rv_decode_pkg::MEM_STORE;
        op_d.adder_use_imm = 1'b1;
        rs1_en = 1'b1;
        rs2_en = 1'b1;
        op_d.illegal = f3[2];
      end
      rv_decode_pkg::OPCODE_LUI: begin
        op_d.adder_use_imm = 1'b1;
        rd_en = 1'b1;
      end
      rv_decode_pkg::OPCODE_AUIPC: begin
        op_d.adder_use_pc  = 1'b1;
        op_d.adder_use_imm = 1'b1;
        rd_en = 1'b1;
      end
      rv_decode_pkg::OPCODE_OP_IMM, rv_decode_pkg::OPCODE_OP_IMM_32: begin
        op_d.use_imm       = 1'b1;
        op_d.adder_use_imm = 1'b1;
        rd_en  = 1'b1;
        rs1_en = 1'b1;
        // Word forms only have ADDIW and the shifts
        if (hold_q.opcode[3]) begin
          op_d.size    = 2'b10;
          op_d.illegal = !(f3 inside {3'b000, 3'b001, 3'b101});
        end
        unique case (f3)
          3'b010: begin
            op_d.alu_op    = rv_decode_pkg::ALU_SCC;
            op_d.condition = rv_decode_pkg::CC_LT;
          end
          3'b011: begin
            op_d.alu_op    = rv_decode_pkg::ALU_SCC;
            op_d.condition = rv_decode_pkg::CC_LTU;
          end
          3'b100: op_d.alu_op = rv_decode_pkg::ALU_XOR;
          3'b110: op_d.alu_op = rv_decode_pkg::ALU_OR;
          3'b111: op_d.alu_op = rv_decode_pkg::ALU_AND;
          3'b001, 3'b101: begin
            op_d.alu_op = rv_decode_pkg::ALU_SHIFT;
            // shamt[5] belongs to funct7[0] only in the 64-bit form
            if (f7[6:1] == 6'b000000 && (!hold_q.opcode[3] || !f7[0])) begin
              op_d.shift_op = f3[2] ? rv_decode_pkg::SHIFT_OP_SRL : rv_decode_pkg::SHIFT_OP_SLL;
            end else if (f3[2] && f7[6:1] == 6'b010000 && (!hold_q.opcode[3] || !f7[0])) begin
              op_d.shift_op = rv_decode_pkg::SHIFT_OP_SRA;
            end else begin
              op_d.illegal = 1'b1;
            end
          end
          default: op_d.alu_op = rv_decode_pkg::ALU_ADD;
        endcase
      end
      rv_decode_pkg::OPCODE_OP, rv_decode_pkg::OPCODE_OP_32: begin
        rd_en  = 1'b1;
        rs1_en = 1'b1;
        rs2_en = 1'b1;
        if (hold_q.opcode[3]) op_d.size = 2'b10;
        unique case ({f7, f3})
          {7'b0000000, 3'b000}: op_d.alu_op = rv_decode_pkg::ALU_ADD;
          {7'b0100000, 3'b000}: op_d.alu_op = rv_decode_pkg::ALU_SUB;
          {7'b0000000, 3'b001}: op_d.alu_op = rv_decode_pkg::ALU_SHIFT;
          {7'b0000000, 3'b101}: begin
            op_d.alu_op   = rv_decode_pkg::ALU_SHIFT;
            op_d.shift_op = rv_decode_pkg::SHIFT_OP_SRL;
          end
          {7'b0100000, 3'b101}: begin
            op_d.alu_op   = rv_decode_pkg::ALU_SHIFT;
            op_d.shift_op = rv_decode_pkg::SHIFT_OP_SRA;
          end
          {7'b0000000, 3'b010}: begin
            op_d.alu_op    = rv_decode_pkg::ALU_SCC;
            op_d.condition = rv_decode_pkg::CC_LT;
            op_d.illegal   = hold_q.opcode[3];
          end
          {7'b0000000, 3'b011}: begin
            op_d.alu_op    = rv_decode_pkg::ALU_SCC;
            op_d.condition = rv_decode_pkg::CC_LTU;
            op_d.illegal   = hold_q.opcode[3];
          end
          {7'b0000000, 3'b100}: begin
            op_d.alu_op  = rv_decode_pkg::ALU_XOR;
            op_d.illegal = hold_q.opcode[3];
          end
          {7'b0000000, 3'b110}: begin
            op_d.alu_op  = rv_decode_pkg::ALU_OR;
            op_d.illegal = hold_q.opcode[3];
          end
          {7'b0000000, 3'b111}: begin
            op_d.alu_op  = rv_decode_pkg::ALU_AND;
            op_d.illegal = hold_q.opcode[3];
          end
          default: op_d.illegal = 1'b1;
        endcase
      end
      rv_decode_pkg::OPCODE_SYSTEM: begin
        // Both sources are read since the backend drains for SYSTEM anyway
        rs1_en = 1'b1;
        rs2_en = 1'b1;
        if (f3 != 3'b000) begin
          op_d.illegal = 1'b1;
        end else begin
          unique case (hold_q.fetch.instr[31:20])
            12'h000: op_d.ecall  = 1'b1;
            12'h001: op_d.ebreak = 1'b1;
            12'h302: begin
              op_d.op_type = rv_decode_pkg::OP_SYSTEM;
              op_d.eret    = 1'b1;
              op_d.illegal = hold_q.fetch.prv != rv_decode_pkg::PRIV_LVL_M;
            end
            default: op_d.illegal = 1'b1;
          endcase
        end
      end
      default: op_d.illegal = 1'b1;
    endcase

    op_d.rd  = rd_en  ? hold_q.rd  : '0;
    op_d.rs1 = rs1_en ? hold_q.rs1 : '0;
    op_d.rs2 = rs2_en ? hold_q.rs2 : '0;
  end

endmodule

//--- design/rv_exc_stage.sv
`timescale 1ns/1ns
`include "rv_decode_params.svh"

module rv_exc_stage (
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  logic                         in_req_i,
  input  rv_decode_pkg::op_item_t      in_data_i,
  output logic                         in_ack_o,
  output logic                         out_req_o,
  output rv_decode_pkg::decoded_item_t out_data_o,
  input  logic                         out_ack_i
);

  rv_decode_pkg::slot_state_e   state_q;
  rv_decode_pkg::op_item_t      hold_q;
  rv_decode_pkg::decoded_item_t dec_d;

  logic capture;
  logic launch;

  assign capture = state_q == rv_decode_pkg::SLOT_EMPTY && in_req_i && !in_ack_o;
  assign launch  = state_q == rv_decode_pkg::SLOT_FULL_WAIT_REQ_LOW;

  ////////////////////
  // Handshake slot
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q   <= rv_decode_pkg::SLOT_EMPTY;
      in_ack_o  <= 1'b0;
      out_req_o <= 1'b0;
    end else begin
      if (in_ack_o && !in_req_i) in_ack_o <= 1'b0;
      unique case (state_q)
        rv_decode_pkg::SLOT_EMPTY: begin
          if (capture) begin
            in_ack_o <= 1'b1;
            state_q  <= rv_decode_pkg::SLOT_FULL_WAIT_REQ_LOW;
          end
        end
        rv_decode_pkg::SLOT_FULL_WAIT_REQ_LOW: begin
          out_req_o <= 1'b1;
          state_q   <= rv_decode_pkg::SLOT_SENDING;
        end
        rv_decode_pkg::SLOT_SENDING: begin
          // Final item stays on the port until the consumer takes it
          if (out_ack_i) begin
            out_req_o <= 1'b0;
            state_q   <= rv_decode_pkg::SLOT_WAIT_ACK_LOW;
          end
        end
        default: begin
          if (!out_ack_i) state_q <= rv_decode_pkg::SLOT_EMPTY;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (capture) hold_q <= in_data_i;
    if (launch) out_data_o <= dec_d;
  end

  ////////////////////
  // Exception select
  ////////////////////

  always_comb begin
    dec_d.pc            = hold_q.pc;
    dec_d.imm           = hold_q.imm;
    dec_d.op_type       = hold_q.op_type;
    dec_d.alu_op        = hold_q.alu_op;
    dec_d.shift_op      = hold_q.shift_op;
    dec_d.condition     = hold_q.condition;
    dec_d.size          = hold_q.size;
    dec_d.size_ext      = hold_q.size_ext;
    dec_d.mem_op        = hold_q.mem_op;
    dec_d.rd            = hold_q.rd;
    dec_d.rs1           = hold_q.rs1;
    dec_d.rs2           = hold_q.rs2;
    dec_d.use_imm       = hold_q.use_imm;
    dec_d.adder_use_pc  = hold_q.adder_use_pc;
    dec_d.adder_use_imm = hold_q.adder_use_imm;
    dec_d.illegal       = hold_q.illegal;
    dec_d.ecall         = hold_q.ecall;
    dec_d.ebreak        = hold_q.ebreak;
    dec_d.eret          = hold_q.eret;
    dec_d.ex_valid      = hold_q.illegal || hold_q.ecall || hold_q.ebreak;
    dec_d.tval          = '0;

    // Illegal wins over ecall, ecall over ebreak
    if (hold_q.illegal) begin
      dec_d.cause = rv_decode_pkg::EXC_CAUSE_ILLEGAL_INSN;
      dec_d.tval  = {{(`RV_XLEN-`RV_ILEN){1'b0}}, hold_q.instr};
    end else if (hold_q.ecall) begin
      // 8 + privilege gives the U, S and M ecall causes
      dec_d.cause = rv_decode_pkg::exc_cause_e'({2'b10, hold_q.prv});
    end else if (hold_q.ebreak) begin
      dec_d.cause = rv_decode_pkg::EXC_CAUSE_BREAKPOINT;
    end else begin
      dec_d.cause = rv_decode_pkg::EXC_CAUSE_ILLEGAL_INSN;
    end
  end

endmodule

//--- design/rv_decoder.sv
`timescale 1ns/1ns

module rv_decoder (
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  logic                         in_req_i,
  input  rv_decode_pkg::fetch_item_t   in_data_i,
  output logic                         in_ack_o,
  output logic                         out_req_o,
  output rv_decode_pkg::decoded_item_t out_data_o,
  input  logic                         out_ack_i
);

  logic                       f2o_req;
  logic                       f2o_ack;
  rv_decode_pkg::field_item_t f2o_data;

  logic                       o2e_req;
  logic                       o2e_ack;
  rv_decode_pkg::op_item_t    o2e_data;

  // Fields and immediate
  rv_field_stage field_stage_i (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .in_req_i   (in_req_i),
    .in_data_i  (in_data_i),
    .in_ack_o   (in_ack_o),
    .out_req_o  (f2o_req),
    .out_data_o (f2o_data),
    .out_ack_i  (f2o_ack)
  );

  // Operation tables and illegal check
  rv_op_stage op_stage_i (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .in_req_i   (f2o_req),
    .in_data_i  (f2o_data),
    .in_ack_o   (f2o_ack),
    .out_req_o  (o2e_req),
    .out_data_o (o2e_data),
    .out_ack_i  (o2e_ack)
  );

  // Exception priority and output hold
  rv_exc_stage exc_stage_i (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .in_req_i   (o2e_req),
    .in_data_i  (o2e_data),
    .in_ack_o   (o2e_ack),
    .out_req_o  (out_req_o),
    .out_data_o (out_data_o),
    .out_ack_i  (out_ack_i)
  );

endmodule

//--- verification/rv_decoder_tb.sv
`timescale 1ns/1ns
`include "rv_decode_params.svh"

module rv_decoder_tb;

  localparam int WAIT_LIMIT = 200;

  logic                         clk_i;
  logic                         reset_i;
  logic                         in_req_i;
  rv_decode_pkg::fetch_item_t   in_data_i;
  logic                         in_ack_o;
  logic                         out_req_o;
  rv_decode_pkg::decoded_item_t out_data_o;
  logic                         out_ack_i;

  // Stimulus and expectations, in file order
  rv_decode_pkg::fetch_item_t   stim_q[$];
  rv_decode_pkg::decoded_item_t exp_q[$];
  string                        name_q[$];

  integer seed;
  int     sent;
  int     received;

  rv_decoder dut_i (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .in_req_i   (in_req_i),
    .in_data_i  (in_data_i),
    .in_ack_o   (in_ack_o),
    .out_req_o  (out_req_o),
    .out_data_o (out_data_o),
    .out_ack_i  (out_ack_i)
  );

  always #50 clk_i = ~clk_i;

  ////////////////////
  // Checking
  ////////////////////

  task automatic stop_run(input string what);
    $display("%s", what);
    $display("FAIL: see errors above");
    $fatal(1, "testbench stopped");
  endtask

  task automatic check_value(input string test, input string field,
                             input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      stop_run($sformatf("mismatch %s %s: expected %h, actual %h", test, field, exp, act));
    end
  endtask

  // Decode fields only matter when no exception is raised
  task automatic compare_item(input string test, input rv_decode_pkg::decoded_item_t exp,
                              input rv_decode_pkg::decoded_item_t act);
    check_value(test, "pc", exp.pc, act.pc);
    check_value(test, "ex_valid", exp.ex_valid, act.ex_valid);
    check_value(test, "tval", exp.tval, act.tval);
    check_value(test, "illegal", exp.illegal, act.illegal);
    check_value(test, "ecall", exp.ecall, act.ecall);
    check_value(test, "ebreak", exp.ebreak, act.ebreak);
    if (exp.ex_valid) begin
      check_value(test, "cause", exp.cause, act.cause);
    end else begin
      check_value(test, "op_type", exp.op_type, act.op_type);
      check_value(test, "alu_op", exp.alu_op, act.alu_op);
      check_value(test, "shift_op", exp.shift_op, act.shift_op);
      check_value(test, "condition", exp.condition, act.condition);
      check_value(test, "size", exp.size, act.size);
      check_value(test, "size_ext", exp.size_ext, act.size_ext);
      check_value(test, "mem_op", exp.mem_op, act.mem_op);
      check_value(test, "rd", exp.rd, act.rd);
      check_value(test, "rs1", exp.rs1, act.rs1);
      check_value(test, "rs2", exp.rs2, act.rs2);
      check_value(test, "use_imm", exp.use_imm, act.use_imm);
      check_value(test, "adder_use_pc", exp.adder_use_pc, act.adder_use_pc);
      check_value(test, "adder_use_imm", exp.adder_use_imm, act.adder_use_imm);
      check_value(test, "imm", exp.imm, act.imm);
      check_value(test, "eret", exp.eret, act.eret);
    end
  endtask

  ////////////////////
  // Test file
  ////////////////////

  task automatic load_tests();
    int                           fd;
    int                           n;
    string                        line;
    string                        tname;
    logic [63:0]                  f [0:18];
    rv_decode_pkg::fetch_item_t   item;
    rv_decode_pkg::decoded_item_t exp;
    fd = $fopen("verification/rv_decoder_tests.txt", "r");
    if (fd == 0) stop_run("cannot open verification/rv_decoder_tests.txt");
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n > 1 && line.getc(0) != "#") begin
        n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    tname, f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
                    f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18]);
        if (n != 20) stop_run({"malformed line in test file: ", line});
        item       = '0;
        item.prv   = rv_decode_pkg::priv_lvl_e'(f[0][1:0]);
        item.instr = f[1][`RV_ILEN-1:0];
        // Each item gets its own pc so order shows up in the output
        item.pc    = 64'h8000_0000 + 64'(4 * stim_q.size());
        exp               = '0;
        exp.pc            = item.pc;
        exp.op_type       = rv_decode_pkg::op_type_e'(f[2][2:0]);
        exp.alu_op        = rv_decode_pkg::alu_op_e'(f[3][2:0]);
        exp.shift_op      = rv_decode_pkg::shift_op_e'(f[4][1:0]);
        exp.condition     = rv_decode_pkg::cond_e'(f[5][2:0]);
        exp.size          = f[6][1:0];
        exp.size_ext      = rv_decode_pkg::size_ext_e'(f[7][0]);
        exp.mem_op        = rv_decode_pkg::mem_op_e'(f[8][0]);
        exp.rd            = f[9][`RV_REG_W-1:0];
        exp.rs1           = f[10][`RV_REG_W-1:0];
        exp.rs2           = f[11][`RV_REG_W-1:0];
        exp.use_imm       = f[12][0];
        exp.adder_use_pc  = f[13][0];
        exp.adder_use_imm = f[14][0];
        exp.imm           = f[15];
        exp.ex_valid      = f[16][0];
        exp.cause         = rv_decode_pkg::exc_cause_e'(f[17][3:0]);
        exp.tval          = f[18];
        // Exception flags follow from the expected cause
        exp.illegal = exp.ex_valid && exp.cause == rv_decode_pkg::EXC_CAUSE_ILLEGAL_INSN;
        exp.ecall   = exp.ex_valid && (exp.cause == rv_decode_pkg::EXC_CAUSE_ECALL_UMODE ||
                                       exp.cause == rv_decode_pkg::EXC_CAUSE_ECALL_SMODE ||
                                       exp.cause == rv_decode_pkg::EXC_CAUSE_ECALL_MMODE);
        exp.ebreak  = exp.ex_valid && exp.cause == rv_decode_pkg::EXC_CAUSE_BREAKPOINT;
        // Only a legal MRET decodes to the system op type
        exp.eret    = !exp.ex_valid && exp.op_type == rv_decode_pkg::OP_SYSTEM;
        stim_q.push_back(item);
        exp_q.push_back(exp);
        name_q.push_back(tname);
      end
    end
    $fclose(fd);
    if (stim_q.size() == 0) stop_run("test file holds no tests");
  endtask

  ////////////////////
  // Driver and collector
  ////////////////////

  // Called on a falling edge with req and ack both low
  task automatic drive_item(input rv_decode_pkg::fetch_item_t item);
    int waited;
    in_data_i = item;
    in_req_i  = 1'b1;
    sent++;
    waited = 0;
    while (!in_ack_o) begin
      @(negedge clk_i);
      waited++;
      if (waited > WAIT_LIMIT) stop_run("timeout waiting for in_ack_o to rise");
    end
    in_req_i = 1'b0;
    waited = 0;
    while (in_ack_o) begin
      @(negedge clk_i);
      waited++;
      if (waited > WAIT_LIMIT) stop_run("timeout waiting for in_ack_o to fall");
    end
  endtask

  task automatic collect_item();
    int                           waited;
    int                           delay;
    string                        tname;
    rv_decode_pkg::decoded_item_t exp;
    waited = 0;
    while (!out_req_o) begin
      @(negedge clk_i);
      waited++;
      if (waited > WAIT_LIMIT) stop_run("timeout waiting for out_req_o to rise");
    end
    if (received >= sent) stop_run("an output item appeared before its input was sent");
    // Random back-pressure of 0 to 5 cycles
    delay = $unsigned($random(seed)) % 6;
    repeat (delay) @(negedge clk_i);
    exp   = exp_q.pop_front();
    tname = name_q.pop_front();
    compare_item(tname, exp, out_data_o);
    received++;
    out_ack_i = 1'b1;
    waited = 0;
    while (out_req_o) begin
      @(negedge clk_i);
      waited++;
      if (waited > WAIT_LIMIT) stop_run("timeout waiting for out_req_o to fall");
    end
    out_ack_i = 1'b0;
  endtask

  initial begin
    clk_i     = 1'b0;
    reset_i   = 1'b1;
    in_req_i  = 1'b0;
    in_data_i = '0;
    out_ack_i = 1'b0;
    seed      = 32'h681a_96a2;
    sent      = 0;
    received  = 0;
    load_tests();

    repeat (10) @(negedge clk_i);
    reset_i = 1'b0;

    // Idle after reset, nothing may come out
    repeat (5) begin
      @(negedge clk_i);
      check_value("reset", "out_req_o", 64'd0, out_req_o);
      check_value("reset", "in_ack_o", 64'd0, in_ack_o);
    end

    fork
      begin
        for (int i = 0; i < stim_q.size(); i++) begin
          drive_item(stim_q[i]);
        end
      end
      begin
        repeat (stim_q.size()) collect_item();
      end
    join

    // No extra item after the last one
    repeat (10) begin
      @(negedge clk_i);
      check_value("drain", "out_req_o", 64'd0, out_req_o);
    end

    $display("PASS: all tests");
    $finish;
  end

endmodule

//--- rv_decoder.f
+incdir+design
design/rv_decode_pkg.sv
design/rv_field_stage.sv
design/rv_op_stage.sv
design/rv_exc_stage.sv
design/rv_decoder.sv
verification/rv_decoder_tb.sv

//--- verification/rv_decoder_tests.txt
# name prv instr op_type alu_op shift_op cond size size_ext mem_op rd rs1 rs2
# use_imm adder_use_pc adder_use_imm imm ex_valid cause tval (hex, cause used only with ex_valid)
add        3 007302b3 0 0 0 0 3 0 0 5 6 7 0 0 0 0 0 0 0
sub        3 407302b3 0 1 0 0 3 0 0 5 6 7 0 0 0 0 0 0 0
slt        3 007322b3 0 2 0 4 3 0 0 5 6 7 0 0 0 0 0 0 0
sltu       3 007332b3 0 2 0 6 3 0 0 5 6 7 0 0 0 0 0 0 0
xor        3 007342b3 0 3 0 0 3 0 0 5 6 7 0 0 0 0 0 0 0
or         3 007362b3 0 4 0 0 3 0 0 5 6 7 0 0 0 0 0 0 0
and        3 007372b3 0 5 0 0 3 0 0 5 6 7 0 0 0 0 0 0 0
sll        3 007312b3 0 6 0 0 3 0 0 5 6 7 0 0 0 0 0 0 0
srl        3 007352b3 0 6 1 0 3 0 0 5 6 7 0 0 0 0 0 0 0
sra        3 407352b3 0 6 2 0 3 0 0 5 6 7 0 0 0 0 0 0 0
addw       3 007302bb 0 0 0 0 2 0 0 5 6 7 0 0 0 0 0 0 0
subw       3 407302bb 0 1 0 0 2 0 0 5 6 7 0 0 0 0 0 0 0
sllw       3 007312bb 0 6 0 0 2 0 0 5 6 7 0 0 0 0 0 0 0
srlw       3 007352bb 0 6 1 0 2 0 0 5 6 7 0 0 0 0 0 0 0
sraw       3 407352bb 0 6 2 0 2 0 0 5 6 7 0 0 0 0 0 0 0
addi       3 fff30293 0 0 0 0 3 0 0 5 6 0 1 0 1 ffffffffffffffff 0 0 0
slti       3 12332293 0 2 0 4 3 0 0 5 6 0 1 0 1 123 0 0 0
sltiu      3 7ff33293 0 2 0 6 3 0 0 5 6 0 1 0 1 7ff 0 0 0
xori       3 80034293 0 3 0 0 3 0 0 5 6 0 1 0 1 fffffffffffff800 0 0 0
ori        3 05536293 0 4 0 0 3 0 0 5 6 0 1 0 1 55 0 0 0
andi       3 0f037293 0 5 0 0 3 0 0 5 6 0 1 0 1 f0 0 0 0
slli       3 03f31293 0 6 0 0 3 0 0 5 6 0 1 0 1 3f 0 0 0
srli       3 00135293 0 6 1 0 3 0 0 5 6 0 1 0 1 1 0 0 0
srai       3 42135293 0 6 2 0 3 0 0 5 6 0 1 0 1 421 0 0 0
addiw      3 0053029b 0 0 0 0 2 0 0 5 6 0 1 0 1 5 0 0 0
slliw      3 01f3129b 0 6 0 0 2 0 0 5 6 0 1 0 1 1f 0 0 0
srliw      3 0033529b 0 6 1 0 2 0 0 5 6 0 1 0 1 3 0 0 0
sraiw      3 4073529b 0 6 2 0 2 0 0 5 6 0 1 0 1 407 0 0 0
ld         3 01033283 3 0 0 0 3 0 0 5 6 0 0 0 1 10 0 0 0
lb         3 ffc30283 3 0 0 0 0 0 0 5 6 0 0 0 1 fffffffffffffffc 0 0 0
lhu        3 00235283 3 0 0 0 1 1 0 5 6 0 0 0 1 2 0 0 0
lwu        3 00836283 3 0 0 0 2 1 0 5 6 0 0 0 1 8 0 0 0
sd         3 02733423 3 0 0 0 3 0 1 0 6 7 0 0 1 28 0 0 0
sb         3 fe730fa3 3 0 0 0 0 0 1 0 6 7 0 0 1 ffffffffffffffff 0 0 0
beq        3 00730463 1 0 0 0 3 0 0 0 6 7 0 1 1 8 0 0 0
bne        3 fe731ce3 1 0 0 1 3 0 0 0 6 7 0 1 1 fffffffffffffff8 0 0 0
blt        3 00734863 1 0 0 4 3 0 0 0 6 7 0 1 1 10 0 0 0
bge        3 007350e3 1 0 0 5 3 0 0 0 6 7 0 1 1 800 0 0 0
bltu       3 02736063 1 0 0 6 3 0 0 0 6 7 0 1 1 20 0 0 0
bgeu       3 00737263 1 0 0 7 3 0 0 0 6 7 0 1 1 4 0 0 0
jal        3 001000ef 2 0 0 0 3 0 0 1 0 0 0 1 1 800 0 0 0
jal_back   3 ffdff2ef 2 0 0 0 3 0 0 5 0 0 0 1 1 fffffffffffffffc 0 0 0
jalr       3 00c302e7 2 0 0 0 3 0 0 5 6 0 0 0 1 c 0 0 0
lui        3 123452b7 0 0 0 0 3 0 0 5 0 0 0 0 1 12345000 0 0 0
lui_neg    3 800002b7 0 0 0 0 3 0 0 5 0 0 0 0 1 ffffffff80000000 0 0 0
auipc      3 00001297 0 0 0 0 3 0 0 5 0 0 0 1 1 1000 0 0 0
mret_m     3 30200073 4 0 0 0 3 0 0 0 0 2 0 0 0 0 0 0 0
ecall_u    0 00000073 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 8 0
ecall_s    1 00000073 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 9 0
ecall_m    3 00000073 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 b 0
ebreak     3 00100073 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 3 0
op_mul     3 027302b3 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 2 027302b3
op32_slt   3 007322bb 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 2 007322bb
slli_f7    3 80131293 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 2 80131293
slliw_sh5  3 0213129b 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 2 0213129b
immw_f3    3 0053229b 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 2 0053229b
br_f3_2    3 00732063 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 2 00732063
br_f3_3    3 00733063 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 2 00733063
st_f3_4    3 00734023 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 2 00734023
ld_f3_7    3 00037283 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 2 00037283
jalr_f3    3 00c312e7 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 2 00c312e7
sret       3 10200073 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 2 10200073
csrrw      3 30029073 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 2 30029073
mret_u     0 30200073 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 2 30200073
mret_s     1 30200073 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 2 30200073
fence      3 0ff0000f 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 2 0ff0000f
opcode_0   3 00000000 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 2 0
